// File: src/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path and register width
`define DATA_W 32
// Word address into the shared memory
`define ADDR_W 10
`define MEM_WORDS 1024
// Register file size
`define REG_CNT 32
// Zero-extended immediate field
`define IMM_W 12

`endif

// File: src/corePkg.sv
`default_nettype none
`include "core_params.svh"

package corePkg;

	// Function codes of the instruction word
	typedef enum logic [3:0] {
		fADD = 4'd0, fSUB = 4'd1, fMULT = 4'd2, fLOAD = 4'd3, fSTR = 4'd4,
		fAVERAGE = 4'd7, fLDA = 4'd8, fSTR_ONE = 4'd12, fHALT = 4'd15
	} functT;

	// Arithmetic codes line up with their funct codes
	typedef enum logic [3:0] {
		aluAdd = 4'd0, aluSub = 4'd1, aluMult = 4'd2, aluAvg = 4'd7, aluPass
	} aluOpT;

	typedef enum logic [1:0] {wbNone, wbAlu, wbMem} wbSrcT;
	typedef enum logic [1:0] {memNone, memLoad, memStore} memOpT;

	// Fetch sequencer and load/store sequencer states
	typedef enum logic [2:0] {stIdle, stFetch, stWait, stHold, stHalt} fetchStateT;
	typedef enum logic [1:0] {msIdle, msReq, msWait} memStateT;

	// Instruction word, high field first
	typedef struct packed {
		functT funct;
		// Immediate as ALU operand B
		logic opcode;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [`IMM_W-1:0] imm;
	} instrT;

	// Decoded control bundle
	typedef struct packed {
		logic aluSrc;
		aluOpT aluOp;
		memOpT memOp;
		wbSrcT wbSrc;
		logic regWrite;
		logic plusOne;
		logic align;
		logic halt;
	} ctrlT;

	// One memory access, shared by all requesters
	typedef struct packed {
		logic we;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} memReqT;

endpackage

`default_nettype wire

// File: src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  corePkg::functT funct,
	input  logic opcode,
	output corePkg::ctrlT ctrl
);
	import corePkg::*;

	always_comb
	begin
		// Everything inactive unless the funct says otherwise
		ctrl = '0;
		ctrl.aluOp = aluPass;
		ctrl.plusOne = (funct == fSTR_ONE);
		ctrl.align = (funct == fLDA);
		case (funct)
			// Register ops, operand B chosen by opcode
			fADD, fSUB, fMULT, fAVERAGE:
			begin
				ctrl.aluSrc = opcode;
				// Same encoding on both sides
				ctrl.aluOp = aluOpT'(funct);
				ctrl.wbSrc = wbAlu;
				ctrl.regWrite = 1'b1;
			end
			// Base plus immediate, result comes back from memory
			fLOAD, fLDA:
			begin
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
				ctrl.memOp = memLoad;
				ctrl.wbSrc = wbMem;
				ctrl.regWrite = 1'b1;
			end
			// Base plus immediate, data from rd
			fSTR, fSTR_ONE:
			begin
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluAdd;
				ctrl.memOp = memStore;
			end
			fHALT:
				ctrl.halt = 1'b1;
			// Unknown codes run as a no-op
			default:
				ctrl.halt = 1'b0;
		endcase
	end

	// Decode table sanity over every funct
	always_comb
	begin
		assert ((ctrl.memOp == memNone || ctrl.wbSrc != wbAlu) && !(ctrl.halt && ctrl.regWrite))
			else $error("controlUnit: conflicting decode for funct %0d", funct);
	end

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module alu (
	input  corePkg::aluOpT op,
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	output logic [`DATA_W-1:0] y
);
	import corePkg::*;

	logic [15:0] gray;

	// Pixel is 0x00RRGGBB, weights add up to 256
	assign gray = 16'd77 * 16'(a[23:16]) + 16'd150 * 16'(a[15:8]) + 16'd29 * 16'(a[7:0]);

	always_comb
	begin
		case (op)
			aluAdd:
				y = a + b;
			aluSub:
				y = a - b;
			// Low word of the product
			aluMult:
				y = a * b;
			aluAvg:
				y = {{(`DATA_W-8){1'b0}}, gray[15:8]};
			// Pass operand B through
			default:
				y = b;
		endcase
	end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module regFile (
	input  logic clk,
	input  logic rst,
	input  logic [$clog2(`REG_CNT)-1:0] rs1,
	input  logic [$clog2(`REG_CNT)-1:0] rs2,
	output logic [`DATA_W-1:0] rd1,
	output logic [`DATA_W-1:0] rd2,
	input  logic aluWe,
	input  logic [$clog2(`REG_CNT)-1:0] aluWaddr,
	input  logic [`DATA_W-1:0] aluWdata,
	input  logic memWe,
	input  logic [$clog2(`REG_CNT)-1:0] memWaddr,
	input  logic [`DATA_W-1:0] memWdata
);
	logic [`DATA_W-1:0] regs [`REG_CNT];

	// r0 reads as zero
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end
		// Load return beats the ALU port
		else if (memWe)
		begin
			if (memWaddr != '0)
				regs[memWaddr] <= memWdata;
		end
		else if (aluWe && aluWaddr != '0)
			regs[aluWaddr] <= aluWdata;
	end

endmodule

`default_nettype wire

// File: src/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module fetchUnit (
	input  logic clk,
	input  logic rst,
	input  logic run,
	output logic req,
	output corePkg::memReqT memReq,
	input  logic grant,
	input  logic rvalid,
	input  logic [`DATA_W-1:0] rdata,
	input  logic done,
	input  logic memBusy,
	output logic issue,
	output corePkg::instrT instr,
	output logic halted
);
	import corePkg::*;

	fetchStateT state;
	logic [`ADDR_W-1:0] pc;
	logic ready;

	// Earlier load or store gone or finishing now
	assign ready = !memBusy || done;
	// Read of the word at pc
	assign req = (state == stFetch);
	assign memReq = '{we: 1'b0, addr: pc, wdata: '0};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
			pc <= '0;
			issue <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			issue <= 1'b0;
			case (state)
				stIdle:
					if (run)
						state <= stFetch;
				stFetch:
					if (grant)
						state <= stWait;
				stWait:
					if (rvalid)
					begin
						pc <= pc + 1'b1;
						state <= stHold;
					end
				// Word buffered, issue once the memory side is free
				stHold:
					if (issue)
						state <= stFetch;
					else if (ready && instr.funct == fHALT)
					begin
						state <= stHalt;
						halted <= 1'b1;
					end
					else if (ready)
						issue <= 1'b1;
				// Halted until reset
				default:
					state <= state;
			endcase
		end
	end

	// Prefetch buffer, doubles as the issued word
	always_ff @(posedge clk)
	begin
		if (state == stWait && rvalid)
			instr <= instrT'(rdata);
	end

	// Never issue over an outstanding load or store
	assert property (@(posedge clk) disable iff (rst) issue |-> !memBusy)
		else $error("fetchUnit: issue while memory op busy");

endmodule

`default_nettype wire

// File: src/memUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module memUnit (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  corePkg::ctrlT ctrl,
	input  logic [`DATA_W-1:0] addr,
	input  logic [`DATA_W-1:0] storeData,
	input  logic [$clog2(`REG_CNT)-1:0] rdAddr,
	output logic req,
	output corePkg::memReqT memReq,
	input  logic grant,
	input  logic rvalid,
	input  logic [`DATA_W-1:0] rdata,
	output logic busy,
	output logic done,
	output logic wbWe,
	output logic [$clog2(`REG_CNT)-1:0] wbAddr,
	output logic [`DATA_W-1:0] wbData
);
	import corePkg::*;

	memStateT state;
	logic accept;

	// Only memory ops are taken from the issue
	assign accept = start && (ctrl.memOp != memNone);
	assign busy = (state != msIdle);
	assign req = (state == msReq);
	// Store ends on its grant, load on the returning word
	assign done = (req && grant && memReq.we) || (state == msWait && rvalid);
	assign wbWe = (state == msWait) && rvalid;
	assign wbData = rdata;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= msIdle;
		else
		begin
			case (state)
				msIdle:
					if (accept)
						state <= msReq;
				// Request held until granted
				msReq:
					if (grant)
						state <= memReq.we ? msIdle : msWait;
				default:
					if (rvalid)
						state <= msIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			memReq.we <= (ctrl.memOp == memStore);
			// LDA drops the low two address bits
			memReq.addr <= ctrl.align ? {addr[`ADDR_W-1:2], 2'b00} : addr[`ADDR_W-1:0];
			memReq.wdata <= storeData + {{(`DATA_W-1){1'b0}}, ctrl.plusOne};
			wbAddr <= rdAddr;
		end
	end

	// Fetch side must wait for done before the next op
	assert property (@(posedge clk) disable iff (rst) accept |-> !busy)
		else $error("memUnit: new op while busy");

endmodule

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
	input  logic clk,
	input  logic rst,
	input  logic hostReq,
	input  corePkg::memReqT hostMem,
	input  logic lsReq,
	input  corePkg::memReqT lsMem,
	input  logic fetchReq,
	input  corePkg::memReqT fetchMem,
	output logic hostGrant,
	output logic lsGrant,
	output logic fetchGrant,
	output logic hostRvalid,
	output logic lsRvalid,
	output logic fetchRvalid,
	output corePkg::memReqT ramReq,
	output logic ramEn
);
	// One-hot owner of the read in flight
	logic [2:0] readOwner;

	// Host first, then load/store, fetch last
	assign hostGrant = hostReq;
	assign lsGrant = lsReq && !hostReq;
	assign fetchGrant = fetchReq && !hostReq && !lsReq;
	assign ramEn = hostReq || lsReq || fetchReq;

	always_comb
	begin
		if (hostGrant)
			ramReq = hostMem;
		else if (lsGrant)
			ramReq = lsMem;
		else
			ramReq = fetchMem;
	end

	// Writes return nothing
	always_ff @(posedge clk)
	begin
		if (rst)
			readOwner <= '0;
		else
			readOwner <= {hostGrant, lsGrant, fetchGrant} & {3{!ramReq.we}};
	end

	assign {hostRvalid, lsRvalid, fetchRvalid} = readOwner;

	assert property (@(posedge clk) disable iff (rst) $onehot0({hostGrant, lsGrant, fetchGrant}))
		else $error("memArbiter: multiple grants");

endmodule

`default_nettype wire

// File: src/sharedRam.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module sharedRam (
	input  logic clk,
	input  logic en,
	input  corePkg::memReqT req,
	output logic [`DATA_W-1:0] rdata
);
	logic [`DATA_W-1:0] mem [`MEM_WORDS];

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			// Write-first, new word shows on the read port
			if (req.we)
			begin
				mem[req.addr] <= req.wdata;
				rdata <= req.wdata;
			end
			else
				rdata <= mem[req.addr];
		end
	end

endmodule

`default_nettype wire

// File: src/imgCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module imgCore (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic hostReq,
	input  logic hostWe,
	input  logic [`ADDR_W-1:0] hostAddr,
	input  logic [`DATA_W-1:0] hostWdata,
	output logic hostRvalid,
	output logic [`DATA_W-1:0] hostRdata,
	output logic halted
);
	import corePkg::*;

	instrT instr;
	ctrlT ctrl;
	memReqT hostMem;
	memReqT lsMem;
	memReqT fetchMem;
	memReqT ramReq;
	logic issue, memBusy, memDone, aluWe, wbWe, ramEn;
	logic lsReq, fetchReq, lsGrant, fetchGrant, lsRvalid, fetchRvalid;
	logic [$clog2(`REG_CNT)-1:0] port2Addr;
	logic [$clog2(`REG_CNT)-1:0] wbAddr;
	logic [`DATA_W-1:0] rd1, rd2, aluB, aluY, wbData, ramRdata;

	// Host side bundled like any other requester
	assign hostMem = '{we: hostWe, addr: hostAddr, wdata: hostWdata};
	assign hostRdata = ramRdata;
	// Store data register sits in rd
	assign port2Addr = (ctrl.memOp == memStore) ? instr.rd : instr.rs2;
	assign aluB = ctrl.aluSrc ? {{(`DATA_W-`IMM_W){1'b0}}, instr.imm} : rd2;
	// ALU result lands on the issue cycle
	assign aluWe = issue && ctrl.regWrite && (ctrl.wbSrc == wbAlu);

	controlUnit i_ctrl (.funct(instr.funct), .opcode(instr.opcode), .ctrl(ctrl));
	alu i_alu (.op(ctrl.aluOp), .a(rd1), .b(aluB), .y(aluY));
	regFile i_regs (
		.clk, .rst, .rs1(instr.rs1), .rs2(port2Addr), .rd1, .rd2,
		.aluWe, .aluWaddr(instr.rd), .aluWdata(aluY),
		.memWe(wbWe), .memWaddr(wbAddr), .memWdata(wbData)
	);
	fetchUnit i_fetch (
		.clk, .rst, .run, .req(fetchReq), .memReq(fetchMem), .grant(fetchGrant),
		.rvalid(fetchRvalid), .rdata(ramRdata), .done(memDone), .memBusy,
		.issue, .instr, .halted
	);
	memUnit i_mem (
		.clk, .rst, .start(issue), .ctrl, .addr(aluY), .storeData(rd2), .rdAddr(instr.rd),
		.req(lsReq), .memReq(lsMem), .grant(lsGrant), .rvalid(lsRvalid), .rdata(ramRdata),
		.busy(memBusy), .done(memDone), .wbWe, .wbAddr, .wbData
	);
	// Host is always granted, so its grant stays inside
	memArbiter i_arb (
		.clk, .rst, .hostReq, .hostMem, .lsReq, .lsMem, .fetchReq, .fetchMem,
		.hostGrant(), .lsGrant, .fetchGrant, .hostRvalid, .lsRvalid, .fetchRvalid,
		.ramReq, .ramEn
	);
	sharedRam i_ram (.clk, .en(ramEn), .req(ramReq), .rdata(ramRdata));

endmodule

`default_nettype wire

// File: dv/imgCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module imgCoreTb;

	localparam int RandCount = 60;
	// Random part, r1 setup, 32 result stores and the HALT
	localparam int ProgLen = RandCount + 34;
	localparam int DataBase = 'h200;
	localparam int ResultBase = 'h300;
	localparam int RunTimeout = 20000;
	localparam int ReadTimeout = 10;

	logic clk;
	logic rst;
	logic run;
	logic hostReq;
	logic hostWe;
	logic [`ADDR_W-1:0] hostAddr;
	logic [`DATA_W-1:0] hostWdata;
	logic hostRvalid;
	logic [`DATA_W-1:0] hostRdata;
	logic halted;

	// Memory image that the ISA model advances in place
	logic [31:0] modelMem [`MEM_WORDS];
	logic [31:0] modelRegs [32];

	imgCore i_dut (
		.clk, .rst, .run, .hostReq, .hostWe, .hostAddr, .hostWdata,
		.hostRvalid, .hostRdata, .halted
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Fields high to low are funct, opcode, rd, rs1, rs2 and imm
	function automatic logic [31:0] encode(int funct, int opc, int rd, int rs1, int rs2, int imm);
		return {funct[3:0], opc[0], rd[4:0], rs1[4:0], rs2[4:0], imm[11:0]};
	endfunction

	// Weighted gray of a 0x00RRGGBB pixel
	function automatic logic [31:0] grayOf(logic [31:0] pix);
		return (32'd77 * pix[23:16] + 32'd150 * pix[15:8] + 32'd29 * pix[7:0]) >> 8;
	endfunction

	function automatic void writeReg(logic [4:0] rd, logic [31:0] value);
		// r0 is hardwired
		if (rd != 5'd0)
			modelRegs[rd] = value;
	endfunction

	function automatic string regionName(int addr);
		if (addr >= ResultBase && addr < ResultBase + 32)
			return $sformatf("result word r%0d", addr - ResultBase);
		else if (addr >= DataBase && addr < ResultBase)
			return $sformatf("data word 0x%0h", addr);
		else if (addr < ProgLen)
			return $sformatf("program word %0d", addr);
		else
			return $sformatf("untouched word 0x%0h", addr);
	endfunction

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic reportTimeout(string what);
		$display("Timeout, %s", what);
		$display("sim failed");
		$fatal(1, "stopping on timeout");
	endtask

	task automatic writeWord(int addr, logic [31:0] data);
		@(negedge clk);
		hostReq = 1'b1;
		hostWe = 1'b1;
		hostAddr = addr[`ADDR_W-1:0];
		hostWdata = data;
	endtask

	task automatic readWord(input int addr, output logic [31:0] data);
		int waitCycles;
		@(negedge clk);
		hostReq = 1'b1;
		hostWe = 1'b0;
		hostAddr = addr[`ADDR_W-1:0];
		@(negedge clk);
		hostReq = 1'b0;
		waitCycles = 0;
		// Data one cycle after the grant
		while (!hostRvalid && waitCycles < ReadTimeout)
		begin
			@(negedge clk);
			waitCycles++;
		end
		if (!hostRvalid)
			reportTimeout($sformatf("no host read data for address 0x%0h", addr));
		data = hostRdata;
	endtask

	task automatic buildProgram();
		int kind;
		int funct;
		int rd;
		int rs1;
		int rs2;
		int imm;
		int opc;
		int functOf [10] = '{0, 1, 2, 7, 3, 8, 4, 12, 0, 3};
		int unknownCodes [7] = '{5, 6, 9, 10, 11, 13, 14};
		// Background fill carries the full address
		for (int a = 0; a < `MEM_WORDS; a++)
			modelMem[a] = 32'hF00D0000 | a;
		for (int a = DataBase; a < ResultBase; a++)
			modelMem[a] = {8'h00, 24'($urandom())};
		// r1 is the base of every load and store
		modelMem[0] = encode(0, 1, 1, 0, 0, DataBase);
		for (int i = 1; i <= RandCount; i++)
		begin
			kind = $urandom_range(0, 9);
			rd = ($urandom_range(0, 7) == 0) ? 0 : $urandom_range(2, 31);
			rs1 = $urandom_range(0, 31);
			rs2 = $urandom_range(0, 31);
			imm = $urandom_range(0, 4095);
			opc = $urandom_range(0, 1);
			funct = (kind == 8) ? unknownCodes[$urandom_range(0, 6)] : functOf[kind];
			// Loads and stores stay inside the data area
			if (funct inside {3, 4, 8, 12})
			begin
				rs1 = 1;
				imm = $urandom_range(0, 255);
			end
			// Store data may come from any register
			if (funct inside {4, 12})
				rd = $urandom_range(0, 31);
			modelMem[i] = encode(funct, opc, rd, rs1, rs2, imm);
		end
		// Dump every register behind the data area
		for (int r = 0; r < 32; r++)
			modelMem[RandCount + 1 + r] = encode(4, 0, r, 1, 0, ResultBase - DataBase + r);
		modelMem[ProgLen - 1] = encode(15, 0, 0, 0, 0, 0);
	endtask

	task automatic runModel();
		int pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [9:0] ea;
		logic [4:0] rd;
		logic stop;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		pc = 0;
		stop = 1'b0;
		// Straight-line code lets the length bound the loop
		while (!stop && pc < ProgLen)
		begin
			w = modelMem[pc];
			pc++;
			rd = w[26:22];
			a = modelRegs[w[21:17]];
			b = w[27] ? {20'b0, w[11:0]} : modelRegs[w[16:12]];
			// Word address wraps at the memory depth
			ea = 10'(a + {20'b0, w[11:0]});
			case (w[31:28])
				4'd0: writeReg(rd, a + b);
				4'd1: writeReg(rd, a - b);
				4'd2: writeReg(rd, a * b);
				4'd7: writeReg(rd, grayOf(a));
				4'd3: writeReg(rd, modelMem[ea]);
				4'd8: writeReg(rd, modelMem[{ea[9:2], 2'b00}]);
				4'd4: modelMem[ea] = modelRegs[rd];
				4'd12: modelMem[ea] = modelRegs[rd] + 32'd1;
				4'd15: stop = 1'b1;
				// Unknown funct does nothing
				default: stop = 1'b0;
			endcase
		end
	endtask

	initial
	begin
		int cycles;
		logic [31:0] readBack;
		void'($urandom(89));
		rst = 1'b1;
		run = 1'b0;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWdata = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		checkValue("halted after reset", 32'd0, halted);
		buildProgram();
		for (int a = 0; a < `MEM_WORDS; a++)
			writeWord(a, modelMem[a]);
		@(negedge clk);
		hostReq = 1'b0;
		hostWe = 1'b0;
		checkValue("halted before run", 32'd0, halted);
		runModel();
		run = 1'b1;
		cycles = 0;
		while (!halted && cycles < RunTimeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
			reportTimeout("halted never rose after run");
		run = 1'b0;
		// Whole memory against the model including untouched words
		for (int a = 0; a < `MEM_WORDS; a++)
		begin
			readWord(a, readBack);
			checkValue(regionName(a), modelMem[a], readBack);
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/corePkg.sv
src/controlUnit.sv
src/alu.sv
src/regFile.sv
src/fetchUnit.sv
src/memUnit.sv
src/memArbiter.sv
src/sharedRam.sv
src/imgCore.sv
dv/imgCoreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module imgCoreTb -o imgCoreSim \
	&& ./obj_dir/imgCoreSim | tee /dev/stderr | grep "sim passed" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
